// File: project.f
verilog/mcntrl_test_pkg.sv
verilog/cmd_deser.sv
verilog/chn_test_ctrl.sv
verilog/status_generate.sv
verilog/status_router.sv
verilog/mcntrl_test_top.sv
dv/tb_mcntrl_test.sv

// File: dv/tb_mcntrl_test.sv
// testbench for the memory controller test port
// command table, channel model, status packet collector and checks
`timescale 1ns/1ns

module tb_mcntrl_test;
    import mcntrl_test_pkg::*;

    localparam int NROWS      = 15;
    localparam int RQ_TIMEOUT = 64;   // cycles allowed for status_rq

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic [4:0]  pr2, pr3, pr4;   // page_ready pulses before the command
        logic [2:0]  fdone;           // frame_done pulse, bit 0 is channel 2
        logic [2:0]  exp_fs, exp_np, exp_susp;
        logic        exp_pkt;         // status write expects a packet
        logic        serve;           // answer all pending requests after this row
    } row_t;

    logic                         mclk, rst, cmd_stb, status_start;
    logic [7:0]                   cmd_ad;
    logic [2:0]                   page_ready, frame_done;   // bit 0 is channel 2
    logic [FRAME_HEIGHT_BITS-1:0] line_val [3];
    wire  [7:0]                   status_ad;
    wire                          status_rq;
    wire  [2:0]                   frame_start, next_page, suspend;

    row_t                         rows [NROWS];
    logic [PAGE_BITS-1:0]         page_m [3];   // model of page counters
    logic                         busy_m [3];
    logic [5:0]                   seq_m [3];
    logic [FRAME_HEIGHT_BITS-1:0] line_m [3];
    logic [7:0]                   stat_addr [3];
    logic [2:0]                   pending;      // packets not yet collected
    int                           first_ch;     // first requester of a group
    int                           errors, checks;
    logic [31:0]                  rnd;

    mcntrl_test_top mcntrl_test_top_i (
        .mclk, .rst, .cmd_ad, .cmd_stb, .status_ad, .status_rq, .status_start,
        .frame_start_chn2 (frame_start[0]), .next_page_chn2 (next_page[0]),
        .suspend_chn2 (suspend[0]), .page_ready_chn2 (page_ready[0]),
        .frame_done_chn2 (frame_done[0]), .line_unfinished_chn2 (line_val[0]),
        .frame_start_chn3 (frame_start[1]), .next_page_chn3 (next_page[1]),
        .suspend_chn3 (suspend[1]), .page_ready_chn3 (page_ready[1]),
        .frame_done_chn3 (frame_done[1]), .line_unfinished_chn3 (line_val[1]),
        .frame_start_chn4 (frame_start[2]), .next_page_chn4 (next_page[2]),
        .suspend_chn4 (suspend[2]), .page_ready_chn4 (page_ready[2]),
        .frame_done_chn4 (frame_done[2]), .line_unfinished_chn4 (line_val[2])
    );

    always #50 mclk = ~mclk;   // 100 ns period

    function automatic row_t table_row(input logic [15:0] addr, input logic [7:0] data,
                                       input logic [4:0] pr2, input logic [4:0] pr3,
                                       input logic [4:0] pr4, input logic [2:0] fdone,
                                       input logic [2:0] exp_fs, input logic [2:0] exp_np,
                                       input logic [2:0] exp_susp, input logic exp_pkt,
                                       input logic serve);
        return {addr, data, pr2, pr3, pr4, fdone, exp_fs, exp_np, exp_susp, exp_pkt, serve};
    endfunction

    function automatic int next_round_robin(input int last, input logic [2:0] mask);
        for (int i = 1; i <= 3; i++) begin
            if (mask[(last + i) % 3])
                return (last + i) % 3;   // first requester after the last grant
        end
        return last;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s: expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic pulse_channel_inputs(input row_t r);
        logic [4:0] cnt [3];
        cnt[0] = r.pr2;
        cnt[1] = r.pr3;
        cnt[2] = r.pr4;
        for (int i = 0; i < 20; i++) begin
            @(posedge mclk);
            for (int ch = 0; ch < 3; ch++) begin
                page_ready[ch] <= (i < cnt[ch]);   // one count per high cycle
                if (i < cnt[ch])
                    page_m[ch] = page_m[ch] + 1'b1;  // wraps at 16
            end
        end
        @(posedge mclk);
        page_ready <= '0;
        frame_done <= r.fdone;
        @(posedge mclk);
        frame_done <= '0;
        for (int ch = 0; ch < 3; ch++)
            if (r.fdone[ch])
                busy_m[ch] = 1'b0;
    endtask

    task automatic send_command(input logic [15:0] addr, input logic [7:0] data);
        @(posedge mclk);
        cmd_stb <= 1'b1;
        cmd_ad  <= addr[7:0];
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= addr[15:8];
        @(posedge mclk);
        cmd_ad  <= data;
        @(posedge mclk);
        cmd_ad  <= 8'h00;          // cmd_we cycle starts here
    endtask

    task automatic check_pulses(input row_t r);
        for (int cyc = 1; cyc <= 3; cyc++) begin
            @(negedge mclk);
            compare_value("frame_start_chn4..2", frame_start, (cyc == 2) ? r.exp_fs : 3'b000);
            compare_value("next_page_chn4..2", next_page, (cyc == 2) ? r.exp_np : 3'b000);
            if (cyc < 3)
                @(posedge mclk);
        end
        compare_value("suspend_chn4..2", suspend, r.exp_susp);
    endtask

    task automatic apply_to_model(input row_t r);
        logic       hit;
        logic [3:0] code;
        int         ch;
        hit  = (((r.addr ^ 16'h00f0) & 16'h03f0) == 16'h0000);
        code = r.addr[3:0];
        ch   = (int'(code) - 4) / 2;                 // codes 4..9 pair up per channel
        if (hit && code >= 4'h4 && code <= 4'h9) begin
            if (!code[0] && r.data[0]) begin         // mode write with frame start
                page_m[ch] = '0;
                busy_m[ch] = 1'b1;
            end
            if (code[0]) begin                       // status-control write
                seq_m[ch] = r.data[7:2];
                if (r.exp_pkt) begin
                    if (pending == 3'b000)
                        first_ch = ch;               // router idle, granted at once
                    pending[ch] = 1'b1;
                end
            end
        end
    endtask

    task automatic collect_packet(input int ch);
        logic [7:0]                     pkt [STATUS_PKT_BYTES];
        logic [STATUS_PAYLOAD_BITS-1:0] exp_pl;
        int                             wait_cnt;
        wait_cnt = 0;
        @(negedge mclk);
        while (status_rq !== 1'b1 && wait_cnt < RQ_TIMEOUT) begin
            @(negedge mclk);
            wait_cnt++;
        end
        checks++;
        assert (status_rq === 1'b1) else begin
            $display("timeout at t=%0t waiting for a status request of channel %0d",
                     $time, ch + 2);
            errors++;
        end
        if (status_rq === 1'b1) begin
            rnd = $urandom % 7;
            repeat (rnd) @(posedge mclk);            // outside side is slow to answer
            @(posedge mclk);
            status_start <= 1'b1;
            for (int i = 0; i < STATUS_PKT_BYTES; i++) begin
                @(negedge mclk);
                pkt[i] = status_ad;
                @(posedge mclk);
                status_start <= 1'b0;
            end
            exp_pl = STATUS_PAYLOAD_BITS'({page_m[ch], line_m[ch], busy_m[ch], busy_m[ch]});
            compare_value($sformatf("status_ad addr chn%0d", ch + 2), pkt[0], stat_addr[ch]);
            compare_value($sformatf("status_ad seq chn%0d", ch + 2), pkt[1],
                          {seq_m[ch], exp_pl[1:0]});
            compare_value($sformatf("status_ad line lo chn%0d", ch + 2), pkt[2], exp_pl[9:2]);
            compare_value($sformatf("status_ad line hi chn%0d", ch + 2), pkt[3], exp_pl[17:10]);
            // last byte is zero padding over the page count
            compare_value($sformatf("status_ad page chn%0d", ch + 2), pkt[4], exp_pl[25:18]);
        end
    endtask

    task automatic expect_no_request(input int cycles);
        int seen;
        seen = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge mclk);
            if (status_rq !== 1'b0)
                seen++;
        end
        checks++;
        assert (seen == 0) else begin
            $display("status_rq rose at t=%0t although no packet was due", $time);
            errors++;
        end
    endtask

    task automatic serve_pending();
        int ch;
        ch = first_ch;
        while (pending != 3'b000) begin
            collect_packet(ch);
            pending[ch] = 1'b0;
            ch = next_round_robin(ch, pending);
        end
        expect_no_request(8);                        // nothing sent twice
    endtask

    initial begin
        rnd = $urandom(32'hbf30063a);
        {errors, checks, first_ch} = '0;
        {mclk, cmd_stb, status_start, cmd_ad, page_ready, frame_done, pending} = '0;
        rst = 1'b1;
        stat_addr = '{8'h3c, 8'h3d, 8'h3e};
        for (int ch = 0; ch < 3; ch++) begin
            {line_m[ch], line_val[ch], page_m[ch], busy_m[ch], seq_m[ch]} = '0;
        end
        // addr, data, page_ready 2/3/4, frame_done, frame_start, next_page, suspend, pkt, serve
        rows[0]  = table_row(16'h00f4, 8'h01,  0,  0, 0, 3'b000, 3'b001, 3'b000, 3'b000, 0, 0);
        rows[1]  = table_row(16'h00f6, 8'h02,  0,  0, 0, 3'b000, 3'b000, 3'b010, 3'b000, 0, 0);
        rows[2]  = table_row(16'h00f8, 8'h05,  0,  0, 0, 3'b000, 3'b100, 3'b000, 3'b100, 0, 0);
        rows[3]  = table_row(16'h01f4, 8'h07,  0,  0, 0, 3'b000, 3'b000, 3'b000, 3'b100, 0, 0);
        rows[4]  = table_row(16'h00f4, 8'h04,  0,  0, 0, 3'b000, 3'b000, 3'b000, 3'b101, 0, 0);
        rows[5]  = table_row(16'h00f5, 8'h85,  5,  0, 0, 3'b000, 3'b000, 3'b000, 3'b101, 1, 1);
        rows[6]  = table_row(16'h00f7, 8'h31,  0, 19, 0, 3'b000, 3'b000, 3'b000, 3'b101, 1, 1);
        rows[7]  = table_row(16'h00f9, 8'hfd,  0,  0, 2, 3'b100, 3'b000, 3'b000, 3'b101, 1, 1);
        rows[8]  = table_row(16'h00f8, 8'h01,  0,  0, 0, 3'b000, 3'b100, 3'b000, 3'b001, 0, 0);
        rows[9]  = table_row(16'h00f9, 8'h15,  0,  0, 0, 3'b000, 3'b000, 3'b000, 3'b001, 1, 1);
        rows[10] = table_row(16'h00f4, 8'h02,  0,  0, 0, 3'b000, 3'b000, 3'b001, 3'b000, 0, 0);
        // three ONCE writes held back, served as 3, 4, 2
        rows[11] = table_row(16'h00f7, 8'h45,  0,  0, 0, 3'b000, 3'b000, 3'b000, 3'b000, 1, 0);
        rows[12] = table_row(16'h00f5, 8'hb9,  1,  0, 0, 3'b000, 3'b000, 3'b000, 3'b000, 1, 0);
        rows[13] = table_row(16'h00f9, 8'h69,  0,  2, 0, 3'b000, 3'b000, 3'b000, 3'b000, 1, 1);
        // channel 2 into ONCE_AUTO
        rows[14] = table_row(16'h00f5, 8'hab,  0,  0, 0, 3'b000, 3'b000, 3'b000, 3'b000, 1, 1);

        repeat (3) @(posedge mclk);
        rst <= 1'b0;
        @(negedge mclk);
        compare_value("frame_start_chn4..2", frame_start, 3'b000);
        compare_value("next_page_chn4..2", next_page, 3'b000);
        compare_value("suspend_chn4..2", suspend, 3'b000);
        compare_value("status_rq", status_rq, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            @(posedge mclk);
            for (int ch = 0; ch < 3; ch++) begin
                rnd = $urandom;
                line_m[ch] = rnd[FRAME_HEIGHT_BITS-1:0];   // new unfinished line
                line_val[ch] <= line_m[ch];
            end
            pulse_channel_inputs(rows[r]);
            send_command(rows[r].addr, rows[r].data);
            check_pulses(rows[r]);
            apply_to_model(rows[r]);
            if (rows[r].serve)
                serve_pending();
        end

        // a line change in auto mode gives one fresh packet, then silence
        @(posedge mclk);
        rnd = $urandom;
        line_m[0] = line_m[0] ^ (rnd[FRAME_HEIGHT_BITS-1:0] | 16'h0001);
        line_val[0] <= line_m[0];
        collect_packet(0);
        expect_no_request(40);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: verilog/mcntrl_test_top.sv
// memory controller test port top level
// command deserializer, channel control, three status generators, status router
`timescale 1ns/1ns

module mcntrl_test_top #(
    parameter logic [15:0] CMD_BASE_ADDR    = 16'h00f0,
    parameter logic [15:0] CMD_ADDR_MASK    = 16'h03f0,
    parameter logic [7:0]  STATUS_ADDR_CHN2 = 8'h3c,
    parameter logic [7:0]  STATUS_ADDR_CHN3 = 8'h3d,
    parameter logic [7:0]  STATUS_ADDR_CHN4 = 8'h3e
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad,
    input  logic       cmd_stb,
    output logic [7:0] status_ad,
    output logic       status_rq,
    input  logic       status_start,

    output logic frame_start_chn2, next_page_chn2, suspend_chn2,
    input  logic page_ready_chn2, frame_done_chn2,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0] line_unfinished_chn2,

    output logic frame_start_chn3, next_page_chn3, suspend_chn3,
    input  logic page_ready_chn3, frame_done_chn3,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0] line_unfinished_chn3,

    output logic frame_start_chn4, next_page_chn4, suspend_chn4,
    input  logic page_ready_chn4, frame_done_chn4,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0] line_unfinished_chn4
);
    import mcntrl_test_pkg::*;

    logic                           cmd_we;
    logic [3:0]                     cmd_a;
    logic [7:0]                     cmd_data;
    logic                           status_we_chn2, status_we_chn3, status_we_chn4;
    logic [STATUS_PAYLOAD_BITS-1:0] payload_chn2, payload_chn3, payload_chn4;
    logic [7:0]                     st_ad_chn2, st_ad_chn3, st_ad_chn4;
    logic                           st_rq_chn2, st_rq_chn3, st_rq_chn4;
    logic                           st_start_chn2, st_start_chn3, st_start_chn4;

    cmd_deser #(
        .CMD_BASE_ADDR (CMD_BASE_ADDR),
        .CMD_ADDR_MASK (CMD_ADDR_MASK)
    ) cmd_deser_i (
        .mclk, .rst, .cmd_ad, .cmd_stb, .cmd_a, .cmd_data, .cmd_we
    );

    chn_test_ctrl chn_test_ctrl_i (.*);  // names match one to one

    status_generate #(.STATUS_REG_ADDR(STATUS_ADDR_CHN2)) status_generate_chn2_i (
        .mclk, .rst,
        .status_we (status_we_chn2),
        .wd        (cmd_data),
        .payload   (payload_chn2),
        .st_ad     (st_ad_chn2),
        .st_rq     (st_rq_chn2),
        .st_start  (st_start_chn2)
    );

    status_generate #(.STATUS_REG_ADDR(STATUS_ADDR_CHN3)) status_generate_chn3_i (
        .mclk, .rst,
        .status_we (status_we_chn3),
        .wd        (cmd_data),
        .payload   (payload_chn3),
        .st_ad     (st_ad_chn3),
        .st_rq     (st_rq_chn3),
        .st_start  (st_start_chn3)
    );

    status_generate #(.STATUS_REG_ADDR(STATUS_ADDR_CHN4)) status_generate_chn4_i (
        .mclk, .rst,
        .status_we (status_we_chn4),
        .wd        (cmd_data),
        .payload   (payload_chn4),
        .st_ad     (st_ad_chn4),
        .st_rq     (st_rq_chn4),
        .st_start  (st_start_chn4)
    );

    status_router status_router_i (
        .mclk, .rst,
        .rq_0 (st_rq_chn2), .ad_0 (st_ad_chn2), .start_0 (st_start_chn2),
        .rq_1 (st_rq_chn3), .ad_1 (st_ad_chn3), .start_1 (st_start_chn3),
        .rq_2 (st_rq_chn4), .ad_2 (st_ad_chn4), .start_2 (st_start_chn4),
        .status_rq, .status_ad, .status_start
    );

endmodule

// File: verilog/status_router.sv
// round-robin status router for three packet sources
// one source owns the shared status port for a whole five-byte packet
`timescale 1ns/1ns

module status_router (
    input  logic       mclk,
    input  logic       rst,
    input  logic       rq_0,       // channel 2
    input  logic [7:0] ad_0,
    output logic       start_0,
    input  logic       rq_1,       // channel 3
    input  logic [7:0] ad_1,
    output logic       start_1,
    input  logic       rq_2,       // channel 4
    input  logic [7:0] ad_2,
    output logic       start_2,
    output logic       status_rq,
    output logic [7:0] status_ad,
    input  logic       status_start
);
    import mcntrl_test_pkg::*;

    localparam int NSRC     = 3;
    localparam int CNT_BITS = $clog2(STATUS_PKT_BYTES);

    router_state_e       state;
    logic [NSRC-1:0]     rq;
    logic [NSRC-1:0]     grant;      // one-hot owner of the port
    logic [NSRC-1:0]     pick;
    logic [1:0]          pick_idx;
    logic [1:0]          last;       // last granted source
    logic [CNT_BITS-1:0] byte_cnt;

    assign rq = {rq_2, rq_1, rq_0};

    // nearest requester after the last grant wins, it is visited last
    always_comb begin
        int idx;
        pick     = '0;
        pick_idx = last;
        for (int i = NSRC; i >= 1; i--) begin
            idx = (int'(last) + i) % NSRC;
            if (rq[idx]) begin
                pick      = '0;
                pick[idx] = 1'b1;
                pick_idx  = 2'(idx);
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state    <= ROUTER_IDLE;
            grant    <= '0;
            last     <= 2'(NSRC - 1);    // channel 2 goes first
            byte_cnt <= '0;
        end else begin
            case (state)
                ROUTER_IDLE: if (|rq) begin
                    grant <= pick;
                    last  <= pick_idx;
                    state <= ROUTER_WAIT_START;
                end
                ROUTER_WAIT_START: if (status_start) begin
                    byte_cnt <= CNT_BITS'(1);  // address byte goes out now
                    state    <= ROUTER_SEND;
                end
                ROUTER_SEND: if (byte_cnt == CNT_BITS'(STATUS_PKT_BYTES - 1)) begin
                    grant <= '0;
                    state <= ROUTER_IDLE;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
                default: state <= ROUTER_IDLE;
            endcase
        end
    end

    assign status_rq = (state == ROUTER_WAIT_START) && |(grant & rq);
    assign {start_2, start_1, start_0} =
        (state == ROUTER_WAIT_START && status_start) ? grant : '0;
    assign status_ad = ({8{grant[0]}} & ad_0) | ({8{grant[1]}} & ad_1) | ({8{grant[2]}} & ad_2);

    // one owner while a packet is pending or going out, none when idle
    assert property (@(posedge mclk) disable iff (rst)
        (state == ROUTER_IDLE) ? (grant == '0) : $onehot(grant))
        else $error("status_router: grant does not match the router state");

endmodule

// File: verilog/status_generate.sv
// status packet generator for one channel
// keeps the reporting mode and sequence number, requests the status port
// and sends address, {seq, payload[1:0]} and three more payload bytes
`timescale 1ns/1ns

module status_generate #(
    parameter logic [7:0] STATUS_REG_ADDR = 8'h3c
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic       status_we,   // status-control write for this channel
    input  logic [7:0] wd,          // [7:2] seq, [1:0] mode
    input  logic [mcntrl_test_pkg::STATUS_PAYLOAD_BITS-1:0] payload,
    output logic [7:0] st_ad,
    output logic       st_rq,
    input  logic       st_start     // first byte goes out this cycle
);
    import mcntrl_test_pkg::*;

    localparam int CNT_BITS = $clog2(STATUS_PKT_BYTES);

    status_mode_e                   mode;
    status_mode_e                   wr_mode;
    logic [5:0]                     seq;
    logic [STATUS_PAYLOAD_BITS-1:0] sent;       // payload of the last packet
    logic [CNT_BITS-1:0]            byte_cnt;   // data byte index, 0 when idle
    logic                           once_wr;
    logic                           auto_mode;

    assign wr_mode   = status_mode_e'(wd[1:0]);
    assign once_wr   = status_we && (wr_mode == STATUS_ONCE || wr_mode == STATUS_ONCE_AUTO);
    assign auto_mode = (mode == STATUS_AUTO) || (mode == STATUS_ONCE_AUTO);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode     <= STATUS_OFF;
            seq      <= '0;
            st_rq    <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (status_we) begin
                mode <= wr_mode;
                seq  <= wd[7:2];
            end
            // a pending request absorbs further changes
            if (st_start)
                st_rq <= 1'b0;
            else if (once_wr || (auto_mode && !status_we && (payload != sent)))
                st_rq <= 1'b1;
            if (st_start)
                byte_cnt <= CNT_BITS'(1);
            else if (byte_cnt == CNT_BITS'(STATUS_PKT_BYTES - 1))
                byte_cnt <= '0;
            else if (byte_cnt != '0)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // snapshot at start, also the reference for change detection
    always_ff @(posedge mclk) begin
        if (st_start)
            sent <= payload;
    end

    always_comb begin
        case (byte_cnt)
            CNT_BITS'(1): st_ad = {seq, sent[1:0]};
            CNT_BITS'(2): st_ad = sent[9:2];
            CNT_BITS'(3): st_ad = sent[17:10];
            CNT_BITS'(4): st_ad = sent[25:18];
            default:      st_ad = st_start ? STATUS_REG_ADDR : 8'h00;  // address byte
        endcase
    end

    // router grants only a source that is asking
    assert property (@(posedge mclk) disable iff (rst) st_start |-> st_rq)
        else $error("status_generate: st_start without st_rq");

endmodule

// File: verilog/chn_test_ctrl.sv
// control for frame channels 2, 3 and 4
// mode decode, start/next pulses, suspend levels, page counters, busy flags
// and the status payload of each channel
`timescale 1ns/1ns

module chn_test_ctrl (
    input  logic       mclk,
    input  logic       rst,
    input  logic       cmd_we,
    input  logic [3:0] cmd_a,
    input  logic [7:0] cmd_data,   // bit 0 start, bit 1 next page, bit 2 suspend

    output logic frame_start_chn2, next_page_chn2, suspend_chn2, status_we_chn2,
    input  logic page_ready_chn2, frame_done_chn2,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0]   line_unfinished_chn2,
    output logic [mcntrl_test_pkg::STATUS_PAYLOAD_BITS-1:0] payload_chn2,

    output logic frame_start_chn3, next_page_chn3, suspend_chn3, status_we_chn3,
    input  logic page_ready_chn3, frame_done_chn3,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0]   line_unfinished_chn3,
    output logic [mcntrl_test_pkg::STATUS_PAYLOAD_BITS-1:0] payload_chn3,

    output logic frame_start_chn4, next_page_chn4, suspend_chn4, status_we_chn4,
    input  logic page_ready_chn4, frame_done_chn4,
    input  logic [mcntrl_test_pkg::FRAME_HEIGHT_BITS-1:0]   line_unfinished_chn4,
    output logic [mcntrl_test_pkg::STATUS_PAYLOAD_BITS-1:0] payload_chn4
);
    import mcntrl_test_pkg::*;

    localparam int NCHN = 3;
    localparam int FHB  = FRAME_HEIGHT_BITS;
    localparam int SPB  = STATUS_PAYLOAD_BITS;
    localparam cmd_reg_e MODE_REG [NCHN] = '{REG_CHN2_MODE, REG_CHN3_MODE, REG_CHN4_MODE};
    localparam cmd_reg_e STAT_REG [NCHN] = '{REG_CHN2_STATUS, REG_CHN3_STATUS, REG_CHN4_STATUS};

    cmd_reg_e            reg_sel;
    wire [NCHN-1:0]      page_ready = {page_ready_chn4, page_ready_chn3, page_ready_chn2};
    wire [NCHN-1:0]      frame_done = {frame_done_chn4, frame_done_chn3, frame_done_chn2};
    wire [NCHN*FHB-1:0]  line_all   = {line_unfinished_chn4, line_unfinished_chn3,
                                       line_unfinished_chn2};
    wire [NCHN-1:0]      frame_start;  // index 0 is channel 2
    wire [NCHN-1:0]      next_page;
    wire [NCHN-1:0]      suspend;
    wire [NCHN-1:0]      status_we;
    wire [NCHN*SPB-1:0]  payload_all;

    assign reg_sel = cmd_reg_e'(cmd_a);

    for (genvar i = 0; i < NCHN; i++) begin : g_chn
        logic                 set_mode;
        logic                 fs_r;      // frame_start pulse
        logic                 np_r;      // next_page pulse
        logic                 susp_r;
        logic                 busy_r;
        logic [PAGE_BITS-1:0] page_r;    // pages done in this frame, wraps

        assign set_mode     = cmd_we && (reg_sel == MODE_REG[i]);
        assign status_we[i] = cmd_we && (reg_sel == STAT_REG[i]);  // straight to generator

        always_ff @(posedge mclk or posedge rst) begin
            if (rst) begin
                fs_r   <= 1'b0;
                np_r   <= 1'b0;
                susp_r <= 1'b0;
                busy_r <= 1'b0;
                page_r <= '0;
            end else begin
                fs_r <= set_mode && cmd_data[0];
                np_r <= set_mode && cmd_data[1];
                if (set_mode)
                    susp_r <= cmd_data[2];        // level, held between writes
                if (fs_r)
                    page_r <= '0;
                else if (page_ready[i])
                    page_r <= page_r + 1'b1;
                if (fs_r && !frame_done[i])
                    busy_r <= 1'b1;
                else if (!fs_r && frame_done[i])
                    busy_r <= 1'b0;
            end
        end

        assign frame_start[i] = fs_r;
        assign next_page[i]   = np_r;
        assign suspend[i]     = susp_r;
        assign payload_all[i*SPB +: SPB] =
            SPB'({page_r, line_all[i*FHB +: FHB], busy_r, busy_r});  // zero on top

        // writes from the command bus are at least three cycles apart
        assert property (@(posedge mclk) disable iff (rst) fs_r |=> !fs_r)
            else $error("chn_test_ctrl: frame_start longer than one cycle");
        assert property (@(posedge mclk) disable iff (rst) np_r |=> !np_r)
            else $error("chn_test_ctrl: next_page longer than one cycle");
    end

    assign {frame_start_chn4, frame_start_chn3, frame_start_chn2} = frame_start;
    assign {next_page_chn4, next_page_chn3, next_page_chn2}       = next_page;
    assign {suspend_chn4, suspend_chn3, suspend_chn2}             = suspend;
    assign {status_we_chn4, status_we_chn3, status_we_chn2}       = status_we;
    assign {payload_chn4, payload_chn3, payload_chn2}             = payload_all;

endmodule

// File: verilog/cmd_deser.sv
// byte-serial command deserializer
// collects addr low, addr high and data, matches address under a mask
`timescale 1ns/1ns

module cmd_deser #(
    parameter logic [15:0] CMD_BASE_ADDR = 16'h00f0,
    parameter logic [15:0] CMD_ADDR_MASK = 16'h03f0
) (
    input  logic       mclk,
    input  logic       rst,
    input  logic [7:0] cmd_ad,    // address/data bytes
    input  logic       cmd_stb,   // with the address low byte
    output logic [3:0] cmd_a,     // register code
    output logic [7:0] cmd_data,
    output logic       cmd_we     // one cycle after the data byte
);
    import mcntrl_test_pkg::*;

    localparam int CNT_BITS = $clog2(CMD_NUM_BYTES);
    localparam int SR_BITS  = 8 * CMD_NUM_BYTES;

    logic [CNT_BITS-1:0] byte_cnt;    // index of byte on cmd_ad, 0 when idle
    logic [SR_BITS-1:0]  cmd_sr;      // newest byte enters at the top
    logic                collecting;
    logic                last_byte;   // data byte on the bus
    logic                addr_hit;

    assign collecting = cmd_stb || (byte_cnt != '0);
    assign last_byte  = (byte_cnt == CNT_BITS'(CMD_NUM_BYTES - 1));

    // while data is on the bus, the shifter top holds {addr high, addr low}
    assign addr_hit = (((cmd_sr[SR_BITS-1 -: 16] ^ CMD_BASE_ADDR) & CMD_ADDR_MASK) == '0);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
            cmd_we   <= 1'b0;
        end else begin
            cmd_we <= last_byte && addr_hit;
            if (cmd_stb)
                byte_cnt <= CNT_BITS'(1);
            else if (last_byte)
                byte_cnt <= '0;                 // command complete
            else if (byte_cnt != '0)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (collecting)
            cmd_sr <= {cmd_ad, cmd_sr[SR_BITS-1:8]};  // shift right by a byte
    end

    assign cmd_a    = cmd_sr[3:0];              // addr low after three shifts
    assign cmd_data = cmd_sr[SR_BITS-1 -: 8];

    // a new command only starts once the previous one is fully collected
    assert property (@(posedge mclk) disable iff (rst) cmd_stb |-> (byte_cnt == '0))
        else $error("cmd_deser: cmd_stb inside a command");

endmodule

// File: verilog/mcntrl_test_pkg.sv
// shared widths and packet sizes for the memory controller test port
// register codes, status reporting modes and status router states
package mcntrl_test_pkg;

    localparam int FRAME_HEIGHT_BITS   = 16;  // line_unfinished width
    localparam int PAGE_BITS           = 4;   // page counter lsbs
    localparam int STATUS_PAYLOAD_BITS = 26;  // page, line, busy x2, zero padded on top
    localparam int STATUS_PKT_BYTES    = 5;   // address + 4 data bytes
    localparam int CMD_NUM_BYTES       = 3;   // addr low, addr high, data

    // low 4 address bits of a command
    typedef enum logic [3:0] {
        REG_CHN2_MODE   = 4'h4,
        REG_CHN2_STATUS = 4'h5,
        REG_CHN3_MODE   = 4'h6,
        REG_CHN3_STATUS = 4'h7,
        REG_CHN4_MODE   = 4'h8,
        REG_CHN4_STATUS = 4'h9
    } cmd_reg_e;

    typedef enum logic [1:0] {
        STATUS_OFF       = 2'd0,  // no packets
        STATUS_ONCE      = 2'd1,  // single packet
        STATUS_AUTO      = 2'd2,  // packet on payload change
        STATUS_ONCE_AUTO = 2'd3   // one now, then on change
    } status_mode_e;

    typedef enum logic [1:0] {
        ROUTER_IDLE,
        ROUTER_WAIT_START,
        ROUTER_SEND
    } router_state_e;

endpackage
